//--- rtl/branch_defs.svh
`ifndef BRANCH_DEFS_SVH
`define BRANCH_DEFS_SVH

// ********************
// table sizes
// ********************

// index bits into the history table, one entry per word-aligned PC
`define BHT_DEPTH 10

// history bits per entry, also the pattern table index width
`define PHT_DEPTH 6

// ********************
// counter codes
// ********************

// the upper bit of each code is the predicted direction
`define CNT_SNT 2'b00
`define CNT_WNT 2'b01
`define CNT_WT  2'b11
`define CNT_ST  2'b10

// ********************
// opcodes
// ********************

// bltz, bgez, bltzal and bgezal share this opcode
`define OP_REGIMM    6'b000001
// beq, bne, blez and bgtz all have 0001 in the upper opcode nibble
`define OP_BRANCH_HI 4'b0001

`endif

//--- rtl/branchPkg.sv
package branchPkg;

    // ********************
    // instruction views
    // ********************

    // I-type layout used by beq, bne, blez and bgtz
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
    } branchForm_t;

    // REGIMM layout where the rt field selects the branch flavour
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic        link;
        logic [2:0]  zeroField;
        logic        gez;
        logic [15:0] offset;
    } regimmForm_t;

    // one decode-stage word, read through whichever view fits the opcode
    typedef union packed {
        branchForm_t branchForm;
        regimmForm_t regimmForm;
    } instrWord_t;

    // ********************
    // predictor state
    // ********************

    // two-bit saturating counter, encoded with the CNT_* codes
    typedef logic [1:0] counter_t;

endpackage

//--- rtl/branchDecode.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branchDecode (
    input  branchPkg::instrWord_t instrD,
    input  logic [31:0]           pcD,
    output logic                  branchD,
    output logic [31:0]           predTargetD
);

    import branchPkg::*;

    logic        isBranchGroup;
    logic        isRegimmBranch;
    logic [31:0] offsetExt;

    // ********************
    // branch detection
    // ********************

    // beq, bne, blez and bgtz sit together in opcodes 000100 to 000111
    assign isBranchGroup = (instrD.branchForm.opcode[5:2] == `OP_BRANCH_HI);

    // only rt patterns x000x are conditional branches, the rest of REGIMM is not
    assign isRegimmBranch = (instrD.regimmForm.opcode == `OP_REGIMM) &&
                            (instrD.regimmForm.zeroField == 3'b000);

    assign branchD = isBranchGroup | isRegimmBranch;

    // ********************
    // target
    // ********************

    // word offset, sign-extended and turned into a byte offset
    assign offsetExt = {{14{instrD.branchForm.offset[15]}},
                        instrD.branchForm.offset,
                        2'b00};

    // relative to the delay slot address
    assign predTargetD = pcD + 32'd4 + offsetExt;

endmodule

//--- rtl/localHistory.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module localHistory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           pcD,
    input  logic [31:0]           pcM,
    input  logic                  branchM,
    input  logic                  actualTakeM,
    output logic [`PHT_DEPTH-1:0] historyD,
    output logic [`PHT_DEPTH-1:0] historyM
);

    // one shift register of recent outcomes per word-aligned PC slot
    logic [`PHT_DEPTH-1:0] bht [1 << `BHT_DEPTH];

    logic [`BHT_DEPTH-1:0] readIdx;
    logic [`BHT_DEPTH-1:0] updateIdx;
    logic [`PHT_DEPTH-1:0] shiftedHistory;

    // ********************
    // read ports
    // ********************

    // the two low PC bits are always zero, so the index starts at bit 2
    assign readIdx   = pcD[`BHT_DEPTH+1:2];
    assign updateIdx = pcM[`BHT_DEPTH+1:2];

    // decode sees the table before any write in this cycle
    assign historyD = bht[readIdx];
    assign historyM = bht[updateIdx];

    // ********************
    // write port
    // ********************

    // newest outcome enters at bit 0, the oldest falls off the top
    assign shiftedHistory = {historyM[`PHT_DEPTH-2:0], actualTakeM};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `BHT_DEPTH); i++) begin
                bht[i] <= '0;
            end
        end else if (branchM) begin
            bht[updateIdx] <= shiftedHistory;
        end
    end

endmodule

//--- rtl/patternTable.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module patternTable (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  branchD,
    input  logic [`PHT_DEPTH-1:0] historyD,
    input  logic [`PHT_DEPTH-1:0] historyM,
    input  logic                  branchM,
    input  logic                  actualTakeM,
    output logic                  predTakeD
);

    import branchPkg::*;

    // one saturating counter per history pattern, shared by all branches
    counter_t pht [1 << `PHT_DEPTH];

    counter_t predCounter;
    counter_t updCounter;
    counter_t nextCounter;

    // ********************
    // prediction
    // ********************

    assign predCounter = pht[historyD];

    // upper counter bit gives the direction, non-branches never predict taken
    assign predTakeD = branchD & predCounter[1];

    // ********************
    // training
    // ********************

    assign updCounter = pht[historyM];

    // one step toward the actual outcome, holding at either end
    always_comb begin
        case (updCounter)
            `CNT_SNT: begin
                nextCounter = actualTakeM ? `CNT_WNT : `CNT_SNT;
            end
            `CNT_WNT: begin
                nextCounter = actualTakeM ? `CNT_WT : `CNT_SNT;
            end
            `CNT_WT: begin
                nextCounter = actualTakeM ? `CNT_ST : `CNT_WNT;
            end
            default: begin
                // strongly taken
                nextCounter = actualTakeM ? `CNT_ST : `CNT_WT;
            end
        endcase
    end

    // a counter only moves when the memory stage reports a real branch
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `PHT_DEPTH); i++) begin
                pht[i] <= `CNT_WT;
            end
        end else if (branchM) begin
            pht[historyM] <= nextCounter;
        end
    end

endmodule

//--- rtl/branchPredictor.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branchPredictor (
    input  logic                  clk,
    input  logic                  rst,
    input  branchPkg::instrWord_t instrD,
    input  logic [31:0]           pcD,
    input  logic [31:0]           pcM,
    input  logic                  branchM,
    input  logic                  actualTakeM,
    output logic                  branchD,
    output logic                  predTakeD,
    output logic [31:0]           predTargetD
);

    import branchPkg::*;

    // local history of the decode and memory stage branches
    logic [`PHT_DEPTH-1:0] historyD;
    logic [`PHT_DEPTH-1:0] historyM;

    // ********************
    // decode
    // ********************

    branchDecode decode0 (
        .instrD      (instrD),
        .pcD         (pcD),
        .branchD     (branchD),
        .predTargetD (predTargetD)
    );

    // ********************
    // first level
    // ********************

    localHistory history0 (
        .clk         (clk),
        .rst         (rst),
        .pcD         (pcD),
        .pcM         (pcM),
        .branchM     (branchM),
        .actualTakeM (actualTakeM),
        .historyD    (historyD),
        .historyM    (historyM)
    );

    // ********************
    // second level
    // ********************

    // history selects the counter, so branches with equal patterns share one
    patternTable pattern0 (
        .clk         (clk),
        .rst         (rst),
        .branchD     (branchD),
        .historyD    (historyD),
        .historyM    (historyM),
        .branchM     (branchM),
        .actualTakeM (actualTakeM),
        .predTakeD   (predTakeD)
    );

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 20,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release lands just after an edge, like every other stimulus
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- test/branchPredictor_chk.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module branchPredictorChk (
    input logic                  clk,
    input logic                  rst,
    input logic [31:0]           instrD,
    input logic [31:0]           pcD,
    input logic [31:0]           pcM,
    input logic                  branchM,
    input logic                  actualTakeM,
    input logic                  branchD,
    input logic                  predTakeD,
    input logic [31:0]           predTargetD,
    input logic [`PHT_DEPTH-1:0] historyM
);

    // read by the testbench once the sequence is over
    int failCount = 0;

    logic        wantBranch;
    logic [31:0] wantTarget;

    // ********************
    // expected decode
    // ********************

    // opcodes 0001xx, or REGIMM with rt bits 3:1 clear
    assign wantBranch = (instrD[31:28] == `OP_BRANCH_HI) ||
                        ((instrD[31:26] == `OP_REGIMM) && (instrD[19:17] == 3'b000));

    assign wantTarget = pcD + 32'd4 + ({{16{instrD[15]}}, instrD[15:0]} << 2);

    // ********************
    // properties
    // ********************

    decodeMatch: assert property (@(posedge clk) disable iff (rst) branchD == wantBranch)
    else begin
        failCount++;
        $error("[ERROR] branchD: expected %h, got %h", wantBranch, branchD);
    end

    targetMatch: assert property (@(posedge clk) disable iff (rst) predTargetD == wantTarget)
    else begin
        failCount++;
        $error("[ERROR] predTargetD: expected %h, got %h", wantTarget, predTargetD);
    end

    // every counter starts weakly taken, so any branch predicts taken
    resetPrediction: assert property (@(posedge clk) $fell(rst) |-> predTakeD == branchD)
    else begin
        failCount++;
        $error("[ERROR] predTakeD after reset: expected %h, got %h", branchD, predTakeD);
    end

    historyShift: assert property (@(posedge clk) disable iff (rst)
        ($past(branchM) && (pcM == $past(pcM))) |->
        (historyM == {$past(historyM[`PHT_DEPTH-2:0]), $past(actualTakeM)}))
    else begin
        failCount++;
        $error("the history entry did not shift in the reported outcome");
    end

    historyHold: assert property (@(posedge clk) disable iff (rst)
        (!$past(branchM) && (pcM == $past(pcM))) |-> (historyM == $past(historyM)))
    else begin
        failCount++;
        $error("a history entry changed without a reported branch");
    end

endmodule

//--- test/tbBranchPredictor.sv
`timescale 1ns/1ps
`include "branch_defs.svh"

module tbBranchPredictor;

    import branchPkg::*;

    // the sequence needs about 120 cycles, so 400 leaves a wide margin
    localparam int maxCycles = 400;

    // three PCs on history entries 0, 1 and 2
    localparam logic [31:0] pcA = 32'h0000_1000;
    localparam logic [31:0] pcB = 32'h0000_2004;
    localparam logic [31:0] pcC = 32'h0000_3008;

    logic        clk;
    logic        rst;
    instrWord_t  instrD;
    logic [31:0] pcD;
    logic [31:0] pcM;
    logic        branchM;
    logic        actualTakeM;
    logic        branchD;
    logic        predTakeD;
    logic [31:0] predTargetD;

    integer      seed;
    int          errCount;
    int          assertFails;
    int          cycleCount = 0;
    logic [31:0] rnd;
    logic [31:0] pcRnd;
    logic [5:0]  opcode;
    logic [31:0] beqWord;

    clockGen clkGen0 (
        .clk (clk),
        .rst (rst)
    );

    branchPredictor dut0 (
        .clk         (clk),
        .rst         (rst),
        .instrD      (instrD),
        .pcD         (pcD),
        .pcM         (pcM),
        .branchM     (branchM),
        .actualTakeM (actualTakeM),
        .branchD     (branchD),
        .predTakeD   (predTakeD),
        .predTargetD (predTargetD)
    );

    bind branchPredictor branchPredictorChk chk0 (
        .clk         (clk),
        .rst         (rst),
        .instrD      (instrD),
        .pcD         (pcD),
        .pcM         (pcM),
        .branchM     (branchM),
        .actualTakeM (actualTakeM),
        .branchD     (branchD),
        .predTakeD   (predTakeD),
        .predTargetD (predTargetD),
        .historyM    (historyM)
    );

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("timeout: the test sequence did not end within %0d cycles", maxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // I-type word, rs is arbitrary for prediction
    function automatic logic [31:0] makeWord(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [15:0] offset);
        return {op, 5'd3, rt, offset};
    endfunction

    task automatic driveDecode(input logic [31:0] word, input logic [31:0] pc);
        @(posedge clk);
        #1;
        instrD = word;
        pcD    = pc;
    endtask

    task automatic driveMemory(input logic [31:0] pc, input logic isBranch, input logic taken);
        @(posedge clk);
        #1;
        pcM         = pc;
        branchM     = isBranch;
        actualTakeM = taken;
    endtask

    // the outputs are combinational and settled by the falling edge
    task automatic predictAt(input logic [31:0] word, input logic [31:0] pc,
                             input logic expBranch, input logic expTake);
        driveDecode(word, pc);
        @(negedge clk);
        assert (branchD == expBranch) else begin
            errCount++;
            $display("[ERROR] branchD at pcD %h: expected %h, got %h", pc, expBranch, branchD);
        end
        assert (predTakeD == expTake) else begin
            errCount++;
            $display("[ERROR] predTakeD at pcD %h: expected %h, got %h",
                     pc, expTake, predTakeD);
        end
    endtask

    task automatic checkTarget(input logic [31:0] pc, input int offsetWords);
        logic [31:0] expTarget;
        expTarget = pc + 32'd4 + 32'(offsetWords * 4);
        driveDecode(makeWord(6'b000100, 5'd1, offsetWords[15:0]), pc);
        @(negedge clk);
        assert (predTargetD == expTarget) else begin
            errCount++;
            $display("[ERROR] predTargetD: expected %h, got %h", expTarget, predTargetD);
        end
    endtask

    initial begin
        seed        = 72460;
        errCount    = 0;
        beqWord     = makeWord(6'b000100, 5'd2, 16'h0010);
        // a branch sits in decode while reset is released
        instrD      = beqWord;
        pcD         = '0;
        pcM         = '0;
        branchM     = 1'b0;
        actualTakeM = 1'b0;
        @(negedge rst);

        // ********************
        // non-branches
        // ********************
        for (int i = 0; i < 50; i++) begin
            do begin
                rnd    = $random(seed);
                opcode = rnd[31:26];
            end while ((opcode == `OP_REGIMM) || (opcode[5:2] == `OP_BRANCH_HI));
            pcRnd = $random(seed);
            predictAt({opcode, rnd[25:0]}, {pcRnd[31:2], 2'b00}, 1'b0, 1'b0);
        end
        // REGIMM words outside the branch group
        for (int zf = 1; zf < 8; zf++) begin
            predictAt(makeWord(`OP_REGIMM, {1'b0, zf[2:0], 1'b1}, 16'h0004),
                      32'h0000_0400, 1'b0, 1'b0);
        end

        // ********************
        // branches after reset
        // ********************
        predictAt(beqWord, 32'h0000_0100, 1'b1, 1'b1);
        predictAt(makeWord(6'b000101, 5'd2, 16'h0020), 32'h0000_0104, 1'b1, 1'b1);
        predictAt(makeWord(6'b000110, 5'd0, 16'hfff0), 32'h0000_0108, 1'b1, 1'b1);
        predictAt(makeWord(6'b000111, 5'd0, 16'h0008), 32'h0000_010c, 1'b1, 1'b1);
        predictAt(makeWord(`OP_REGIMM, 5'b00000, 16'h0002), 32'h0000_0110, 1'b1, 1'b1);
        predictAt(makeWord(`OP_REGIMM, 5'b00001, 16'hfffe), 32'h0000_0114, 1'b1, 1'b1);
        predictAt(makeWord(`OP_REGIMM, 5'b10000, 16'h0040), 32'h0000_0118, 1'b1, 1'b1);
        predictAt(makeWord(`OP_REGIMM, 5'b10001, 16'h0100), 32'h0000_011c, 1'b1, 1'b1);

        // ********************
        // targets
        // ********************
        checkTarget(32'h0000_0400, 16);
        checkTarget(32'h0040_0000, -1);
        checkTarget(32'h0040_0000, -32768);
        checkTarget(32'h0000_1000, 32767);

        // ********************
        // training
        // ********************
        // two not-taken reports walk counter 0 down to strongly not taken
        driveMemory(pcA, 1'b1, 1'b0);
        driveMemory(pcA, 1'b1, 1'b0);
        driveMemory(pcA, 1'b0, 1'b0);
        predictAt(beqWord, pcB, 1'b1, 1'b0);
        driveMemory(pcA, 1'b1, 1'b0);
        driveMemory(pcA, 1'b0, 1'b0);
        predictAt(beqWord, pcB, 1'b1, 1'b0);
        predictAt(beqWord, pcA, 1'b1, 1'b0);

        // C moves to history 1 and lifts counter 0 to weakly not taken
        driveMemory(pcC, 1'b1, 1'b1);
        driveMemory(pcC, 1'b0, 1'b0);
        predictAt(beqWord, pcC, 1'b1, 1'b1);
        predictAt(beqWord, pcB, 1'b1, 1'b0);

        // ********************
        // idle memory stage
        // ********************
        for (int i = 0; i < 20; i++) begin
            rnd   = $random(seed);
            pcRnd = $random(seed);
            driveMemory({pcRnd[31:2], 2'b00}, 1'b0, rnd[0]);
        end
        driveMemory(pcC, 1'b0, 1'b1);
        driveMemory(pcC, 1'b0, 1'b0);
        predictAt(beqWord, pcC, 1'b1, 1'b1);
        predictAt(beqWord, pcB, 1'b1, 1'b0);
        predictAt(beqWord, pcA, 1'b1, 1'b0);

        @(posedge clk);
        assertFails = dut0.chk0.failCount;
        $display("checks done: %0d testbench errors, %0d assertion failures",
                 errCount, assertFails);
        if ((errCount == 0) && (assertFails == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/branchPkg.sv
rtl/branchDecode.sv
rtl/localHistory.sv
rtl/patternTable.sv
rtl/branchPredictor.sv
test/clockGen.sv
test/branchPredictor_chk.sv
test/tbBranchPredictor.sv

//--- run.sh
#!/bin/sh
# build the branch predictor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

# assertion errors must not stop the run, so the testbench can count them
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbBranchPredictor -f sources.f -o simBranchPredictor &&
    ./obj_dir/simBranchPredictor +verilator+error+limit+1000 | tee /dev/stderr |
    grep "Simulation completed successfully" > /dev/null &&
    echo "run passed" || { echo "run failed"; exit 1; }
